/* design/huff_mem_config.svh */
`ifndef HUFF_MEM_CONFIG_SVH
`define HUFF_MEM_CONFIG_SVH

// stage ports sharing the sram
`define HM_NUM_PORTS 4

// bus and item geometry
`define HM_WORD_W 32
`define HM_ITEM_WORDS 4
`define HM_INDEX_W 8

// sram word address space
`define HM_ADDR_W 11
`define HM_SRAM_DEPTH 2048
`define HM_SRAM_WAIT 1 // wait states before each ack

// region bases in word addresses
`define HM_HIST_BASE 11'h000
`define HM_HTREE_BASE 11'h100
`define HM_CB_BASE 11'h400

// htree holds 128 nodes
`define HM_HTREE_MASK 8'h7f

`endif

/* design/huff_mem_pkg.sv */
`include "huff_mem_config.svh"

package huff_mem_pkg;

    // encoder stage as driven by the controller
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HIST,
        ST_HTREE,
        ST_CODEBOOK,
        ST_TRANSLATE
    } huff_stage_t;

    // word 0 sits in the top 32 bits
    typedef logic [`HM_ITEM_WORDS*`HM_WORD_W-1:0] item_t;

    // ports in order hist, htree, codebook, translate
    localparam int unsigned port_words [`HM_NUM_PORTS] = '{1, 2, 4, 4};

    // translate reads back what codebook wrote
    localparam logic [`HM_ADDR_W-1:0] port_base [`HM_NUM_PORTS] = '{
        `HM_HIST_BASE,
        `HM_HTREE_BASE,
        `HM_CB_BASE,
        `HM_CB_BASE
    };

    localparam logic [`HM_INDEX_W-1:0] port_idx_mask [`HM_NUM_PORTS] = '{
        8'hff, `HM_HTREE_MASK, 8'hff, 8'hff
    };

    localparam huff_stage_t port_stage [`HM_NUM_PORTS] = '{
        ST_HIST, ST_HTREE, ST_CODEBOOK, ST_TRANSLATE
    };

endpackage

/* design/stage_select.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module stage_select
    import huff_mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  huff_stage_t              stage_i,
    input  logic [`HM_NUM_PORTS-1:0] req_i,
    input  logic                     bus_idle_i,
    input  logic [`HM_NUM_PORTS-1:0] done_i,
    output logic [`HM_NUM_PORTS-1:0] grant_o
);

    logic [`HM_NUM_PORTS-1:0] owner_req;
    logic                     grant_done;

    // each stage owns at most one port so this is one-hot or zero
    always_comb begin
        for (int i = 0; i < `HM_NUM_PORTS; i++) begin
            owner_req[i] = req_i[i] && (port_stage[i] == stage_i);
        end
    end

    assign grant_done = |(grant_o & done_i);

    // grant sticks until done even when the stage changes mid transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_o <= '0;
        end else if (grant_done) begin
            grant_o <= '0;
        end else if (grant_o == '0 && bus_idle_i) begin
            grant_o <= owner_req; // other requests keep waiting
        end
    end

endmodule

/* design/region_port.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module region_port
    import huff_mem_pkg::*;
#(
    parameter int PORT_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   grant_i,
    input  logic                   req_i,
    input  logic                   we_i,
    input  logic [`HM_INDEX_W-1:0] index_i,
    input  item_t                  wdata_i,

    output logic                   beat_req_o,
    output logic                   beat_we_o,
    output logic [`HM_ADDR_W-1:0]  beat_adr_o,
    output logic [`HM_WORD_W-1:0]  beat_dat_o,
    input  logic                   beat_ack_i,
    input  logic [`HM_WORD_W-1:0]  beat_rdata_i,

    output item_t                  rdata_o,
    output logic                   done_o
);

    localparam int unsigned WORDS = port_words[PORT_ID];
    localparam logic [`HM_ADDR_W-1:0] BASE = port_base[PORT_ID];
    localparam logic [`HM_INDEX_W-1:0] IDX_MASK = port_idx_mask[PORT_ID];
    localparam logic [1:0] LAST_BEAT = 2'(WORDS - 1);
    // unused upper words of the item are skipped on writes
    localparam int unsigned PAD = `HM_WORD_W * (`HM_ITEM_WORDS - WORDS);

    typedef enum logic [1:0] {
        P_IDLE,
        P_BEAT,
        P_DONE
    } port_state_t;

    port_state_t            state;
    logic [1:0]             beat_q;
    logic [`HM_INDEX_W-1:0] idx_q;
    logic                   we_q;
    item_t                  dat_q;
    logic                   start;
    logic                   beat_hit;

    assign start    = (state == P_IDLE) && grant_i && req_i;
    assign beat_hit = (state == P_BEAT) && grant_i && beat_ack_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= P_IDLE;
            beat_q <= '0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (start) begin
                        state  <= P_BEAT;
                        beat_q <= '0;
                    end
                end
                P_BEAT: begin
                    if (beat_hit) begin
                        beat_q <= beat_q + 2'd1;
                        if (beat_q == LAST_BEAT) state <= P_DONE;
                    end
                end
                default: state <= P_IDLE; // done lasts one cycle
            endcase
        end
    end

    // item and index captured once per transfer
    always_ff @(posedge clk) begin
        if (start) begin
            idx_q <= index_i & IDX_MASK;
            we_q  <= we_i;
            dat_q <= wdata_i << PAD;
            if (!we_i) rdata_o <= '0;
        end else if (beat_hit) begin
            dat_q <= dat_q << `HM_WORD_W; // next word to the top
            if (!we_q) begin
                rdata_o <= {rdata_o[`HM_ITEM_WORDS*`HM_WORD_W-`HM_WORD_W-1:0], beat_rdata_i};
            end
        end
    end

    // base + index * words + beat
    assign beat_adr_o = BASE + (`HM_ADDR_W'(idx_q) * `HM_ADDR_W'(WORDS))
                      + `HM_ADDR_W'(beat_q);

    assign beat_req_o = (state == P_BEAT);
    assign beat_we_o  = we_q;
    assign beat_dat_o = dat_q[`HM_ITEM_WORDS*`HM_WORD_W-1 -: `HM_WORD_W];
    assign done_o     = (state == P_DONE);

endmodule

/* design/wb_beat_master.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module wb_beat_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`HM_NUM_PORTS-1:0] grant_i,

    // beats from all ports of which only the granted one is taken
    input  logic [`HM_NUM_PORTS-1:0] beat_req_i,
    input  logic [`HM_NUM_PORTS-1:0] beat_we_i,
    input  logic [`HM_ADDR_W-1:0]    beat_adr_i [`HM_NUM_PORTS],
    input  logic [`HM_WORD_W-1:0]    beat_dat_i [`HM_NUM_PORTS],
    output logic                     beat_ack_o,
    output logic [`HM_WORD_W-1:0]    beat_rdata_o,
    output logic                     bus_idle_o,

    // wishbone classic master
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output logic [`HM_ADDR_W-1:0]    wb_adr_o,
    output logic [`HM_WORD_W-1:0]    wb_dat_o,
    input  logic                     wb_ack_i,
    input  logic [`HM_WORD_W-1:0]    wb_dat_i
);

    logic                  sel_req;
    logic                  sel_we;
    logic [`HM_ADDR_W-1:0] sel_adr;
    logic [`HM_WORD_W-1:0] sel_dat;
    logic                  cyc_q;
    logic                  launch;

    // grant is one-hot so an and-or mux is enough
    always_comb begin
        sel_req = 1'b0;
        sel_we  = 1'b0;
        sel_adr = '0;
        sel_dat = '0;
        for (int i = 0; i < `HM_NUM_PORTS; i++) begin
            if (grant_i[i]) begin
                sel_req = sel_req | beat_req_i[i];
                sel_we  = sel_we  | beat_we_i[i];
                sel_adr = sel_adr | beat_adr_i[i];
                sel_dat = sel_dat | beat_dat_i[i];
            end
        end
    end

    // a new cycle only opens once the previous one is closed
    assign launch = !cyc_q && sel_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_q <= 1'b0;
        end else if (cyc_q && wb_ack_i) begin
            cyc_q <= 1'b0; // stb falls the cycle after ack
        end else if (launch) begin
            cyc_q <= 1'b1;
        end
    end

    // address and data held steady for the whole cycle
    always_ff @(posedge clk) begin
        if (launch) begin
            wb_we_o  <= sel_we;
            wb_adr_o <= sel_adr;
            wb_dat_o <= sel_dat;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;

    // ack and read data go back to every port
    assign beat_ack_o   = cyc_q && wb_ack_i;
    assign beat_rdata_o = wb_dat_i;
    assign bus_idle_o   = !cyc_q;

endmodule

/* design/wb_sram.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module wb_sram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`HM_ADDR_W-1:0] wb_adr_i,
    input  logic [`HM_WORD_W-1:0] wb_dat_i,
    output logic                  wb_ack_o,
    output logic [`HM_WORD_W-1:0] wb_dat_o
);

    localparam int CNT_W = $clog2(`HM_SRAM_WAIT + 2);

    logic [`HM_WORD_W-1:0] mem [`HM_SRAM_DEPTH];
    logic [CNT_W-1:0]      wait_cnt;
    logic                  active;
    logic                  hit;

    // contents start cleared
    initial begin
        for (int i = 0; i < `HM_SRAM_DEPTH; i++) mem[i] = '0;
    end

    assign active = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign hit    = active && (wait_cnt == CNT_W'(`HM_SRAM_WAIT));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            wb_ack_o <= 1'b0;
        end else if (hit) begin
            wait_cnt <= '0;
            wb_ack_o <= 1'b1;
        end else begin
            if (active) wait_cnt <= wait_cnt + 1'b1;
            wb_ack_o <= 1'b0; // single cycle ack
        end
    end

    // access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (hit) begin
            if (wb_we_i) mem[wb_adr_i] <= wb_dat_i;
            else wb_dat_o <= mem[wb_adr_i];
        end
    end

endmodule

/* design/huff_mem_top.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module huff_mem_top
    import huff_mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  huff_stage_t              stage_i,

    // one entry per stage port
    input  logic [`HM_NUM_PORTS-1:0] req_i,
    input  logic [`HM_NUM_PORTS-1:0] we_i,
    input  logic [`HM_INDEX_W-1:0]   index_i [`HM_NUM_PORTS],
    input  item_t                    wdata_i [`HM_NUM_PORTS],
    output item_t                    rdata_o [`HM_NUM_PORTS],
    output logic [`HM_NUM_PORTS-1:0] done_o,

    // bus observation
    output logic                     wb_cyc_o,
    output logic                     wb_ack_o
);

    logic [`HM_NUM_PORTS-1:0] grant;
    logic                     bus_idle;

    logic [`HM_NUM_PORTS-1:0] beat_req;
    logic [`HM_NUM_PORTS-1:0] beat_we;
    logic [`HM_ADDR_W-1:0]    beat_adr [`HM_NUM_PORTS];
    logic [`HM_WORD_W-1:0]    beat_dat [`HM_NUM_PORTS];
    logic                     beat_ack;
    logic [`HM_WORD_W-1:0]    beat_rdata;

    logic                     wb_stb;
    logic                     wb_we;
    logic [`HM_ADDR_W-1:0]    wb_adr;
    logic [`HM_WORD_W-1:0]    wb_dat_w;
    logic [`HM_WORD_W-1:0]    wb_dat_r;

    stage_select u_stage_select (
        .clk        (clk),
        .rst        (rst),
        .stage_i    (stage_i),
        .req_i      (req_i),
        .bus_idle_i (bus_idle),
        .done_i     (done_o),
        .grant_o    (grant)
    );

    for (genvar i = 0; i < `HM_NUM_PORTS; i++) begin : g_port
        region_port #(
            .PORT_ID (i)
        ) u_region_port (
            .clk          (clk),
            .rst          (rst),
            .grant_i      (grant[i]),
            .req_i        (req_i[i]),
            .we_i         (we_i[i]),
            .index_i      (index_i[i]),
            .wdata_i      (wdata_i[i]),
            .beat_req_o   (beat_req[i]),
            .beat_we_o    (beat_we[i]),
            .beat_adr_o   (beat_adr[i]),
            .beat_dat_o   (beat_dat[i]),
            .beat_ack_i   (beat_ack),
            .beat_rdata_i (beat_rdata),
            .rdata_o      (rdata_o[i]),
            .done_o       (done_o[i])
        );
    end

    wb_beat_master u_wb_beat_master (
        .clk          (clk),
        .rst          (rst),
        .grant_i      (grant),
        .beat_req_i   (beat_req),
        .beat_we_i    (beat_we),
        .beat_adr_i   (beat_adr),
        .beat_dat_i   (beat_dat),
        .beat_ack_o   (beat_ack),
        .beat_rdata_o (beat_rdata),
        .bus_idle_o   (bus_idle),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_adr_o     (wb_adr),
        .wb_dat_o     (wb_dat_w),
        .wb_ack_i     (wb_ack_o),
        .wb_dat_i     (wb_dat_r)
    );

    wb_sram u_wb_sram (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc_o),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_r)
    );

endmodule

/* tb/huff_mem_asserts.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module huff_mem_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic [`HM_NUM_PORTS-1:0] grant_i,
    input logic                     cyc_i,
    input logic                     stb_i,
    input logic                     ack_i
);

    // slave only answers an open cycle
    ack_in_cyc: assert property (@(posedge clk) disable iff (rst) ack_i |-> cyc_i)
        else $error("ack high while cyc is low");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
        else $error("ack held for more than one cycle");

    // master may not withdraw a strobe before the slave answers
    stb_until_ack: assert property (@(posedge clk) disable iff (rst)
        stb_i && !ack_i |=> stb_i)
        else $error("stb dropped before ack");

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_i))
        else $error("more than one port granted");

endmodule

/* tb/huff_mem_tb.sv */
`timescale 1ns/1ps
`include "huff_mem_config.svh"

module huff_mem_tb
    import huff_mem_pkg::*;
();

    localparam int NP = `HM_NUM_PORTS;
    localparam int N_RAND = 8;
    localparam int N_CB = 6;
    localparam int N_XFERS = NP + 4 * N_RAND + 2 * N_CB + 4;
    localparam int MAX_CYCLES = 40 * N_XFERS;
    localparam huff_stage_t OWNER [NP] = '{ST_HIST, ST_HTREE, ST_CODEBOOK, ST_TRANSLATE};

    logic                   clk;
    logic                   rst;
    huff_stage_t            stage_r;
    logic [NP-1:0]          req_r;
    logic [NP-1:0]          we_r;
    logic [`HM_INDEX_W-1:0] index_r [NP];
    item_t                  wdata_r [NP];
    item_t                  rdata_w [NP];
    logic [NP-1:0]          done_w;
    logic                   wb_cyc_w;
    logic                   wb_ack_w;

    logic [`HM_WORD_W-1:0]  ref_mem [`HM_SRAM_DEPTH];
    logic [NP-1:0]          pend_valid;
    logic [NP-1:0]          pend_we;
    logic [NP-1:0]          held; // requests that must not finish yet
    logic [NP-1:0]          allowed_done;
    logic [`HM_INDEX_W-1:0] pend_idx [NP];
    item_t                  pend_dat [NP];
    logic [`HM_INDEX_W-1:0] idx_list [N_RAND];
    logic [`HM_INDEX_W-1:0] tmp_idx;
    item_t                  tmp_item;
    logic [31:0]            rng;
    int                     error_count;
    int                     cycle_cnt;

    huff_mem_top u_huff_mem_top (
        .clk      (clk),
        .rst      (rst),
        .stage_i  (stage_r),
        .req_i    (req_r),
        .we_i     (we_r),
        .index_i  (index_r),
        .wdata_i  (wdata_r),
        .rdata_o  (rdata_w),
        .done_o   (done_w),
        .wb_cyc_o (wb_cyc_w),
        .wb_ack_o (wb_ack_w)
    );

    bind wb_beat_master huff_mem_asserts u_huff_mem_asserts (
        .clk(clk), .rst(rst), .grant_i(grant_i),
        .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .ack_i(wb_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic rand_item(output item_t it);
        for (int w = 0; w < `HM_ITEM_WORDS; w++) begin
            rng = xorshift32(rng);
            it[w*32 +: 32] = rng;
        end
    endtask

    function automatic int words_of(input int p);
        return (p == 0) ? 1 : (p == 1) ? 2 : 4;
    endfunction

    // base + index * words + beat with the htree index wrapping at 128 nodes
    function automatic int word_addr(input int p, input logic [7:0] idx, input int beat);
        case (p)
            0: return `HM_HIST_BASE + int'(idx) + beat;
            1: return `HM_HTREE_BASE + (int'(idx) % 128) * 2 + beat;
            default: return `HM_CB_BASE + int'(idx) * 4 + beat; // translate shares it
        endcase
    endfunction

    // beat 0 is the top used word and the item sits in the low words
    function automatic item_t ref_read(input int p, input logic [7:0] idx);
        item_t it;
        int    w;
        it = '0;
        w = words_of(p);
        for (int b = 0; b < w; b++) it[(w-1-b)*32 +: 32] = ref_mem[word_addr(p, idx, b)];
        return it;
    endfunction

    task automatic ref_write(input int p, input logic [7:0] idx, input item_t it);
        int w;
        w = words_of(p);
        for (int b = 0; b < w; b++) ref_mem[word_addr(p, idx, b)] = it[(w-1-b)*32 +: 32];
    endtask

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_item(input string name, input item_t got, input item_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_done_port(input string name, input logic [NP-1:0] got,
                                   input logic [NP-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // stage holds req and data until done
    task automatic run_transfer(input int p, input logic we, input logic [7:0] idx,
                                input item_t dat);
        @(negedge clk);
        pend_we[p]  = we;
        pend_idx[p] = idx;
        pend_dat[p] = dat;
        pend_valid[p] = 1'b1;
        we_r[p]    = we;
        index_r[p] = idx;
        wdata_r[p] = dat;
        req_r[p]   = 1'b1;
        @(negedge clk);
        while (!done_w[p]) @(negedge clk);
        req_r[p] = 1'b0;
        @(negedge clk);
    endtask

    // every done pulse checked against the model
    always @(negedge clk) begin
        if (!rst) begin
            allowed_done = pend_valid & ~held;
            check_done_port("done_o", done_w & ~allowed_done, '0);
            for (int p = 0; p < NP; p++) begin
                if (done_w[p] && pend_we[p]) begin
                    ref_write(p, pend_idx[p], pend_dat[p]);
                end else if (done_w[p]) begin
                    check_item($sformatf("rdata_o[%0d]", p), rdata_w[p],
                               ref_read(p, pend_idx[p]));
                end
                if (done_w[p]) pend_valid[p] = 1'b0; // one done per request
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: transfers not finished within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    initial begin
        rng = 32'd29426;
        error_count = 0;
        cycle_cnt = 0;
        rst = 1'b1;
        stage_r = ST_IDLE;
        req_r = '0;
        we_r = '0;
        held = '0;
        pend_valid = '0;
        pend_we = '0;
        for (int p = 0; p < NP; p++) begin
            index_r[p] = '0;
            wdata_r[p] = '0;
        end
        for (int a = 0; a < `HM_SRAM_DEPTH; a++) ref_mem[a] = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("wb_cyc_o", wb_cyc_w, 1'b0);
        check_flag("wb_ack_o", wb_ack_w, 1'b0);
        check_done_port("done_o", done_w, '0);
        for (int p = 0; p < NP; p++) begin // empty memory reads back zero
            stage_r = OWNER[p];
            rng = xorshift32(rng);
            run_transfer(p, 1'b0, rng[7:0], '0);
        end

        stage_r = ST_HIST;
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift32(rng);
            idx_list[i] = rng[7:0];
            rand_item(tmp_item);
            run_transfer(0, 1'b1, idx_list[i], tmp_item);
        end
        for (int i = 0; i < N_RAND; i++) run_transfer(0, 1'b0, idx_list[i], '0);

        // written above 127 and read below
        stage_r = ST_HTREE;
        for (int i = 0; i < N_RAND; i++) begin
            rand_item(tmp_item);
            run_transfer(1, 1'b1, idx_list[i] | 8'h80, tmp_item);
        end
        for (int i = 0; i < N_RAND; i++) run_transfer(1, 1'b0, idx_list[i] & 8'h7f, '0);

        stage_r = ST_CODEBOOK;
        for (int i = 0; i < N_CB; i++) begin
            rand_item(tmp_item);
            run_transfer(2, 1'b1, idx_list[i], tmp_item);
        end
        stage_r = ST_TRANSLATE;
        for (int i = 0; i < N_CB; i++) run_transfer(3, 1'b0, idx_list[i], '0);

        // translate waits while hist owns the bus
        stage_r = ST_HIST;
        rand_item(tmp_item);
        held[3] = 1'b1;
        fork
            run_transfer(3, 1'b0, idx_list[0], '0);
            begin
                run_transfer(0, 1'b1, idx_list[1], tmp_item);
                repeat (30) @(negedge clk);
                held[3] = 1'b0;
                stage_r = ST_TRANSLATE;
            end
        join

        // stage moves on mid transfer
        stage_r = ST_CODEBOOK;
        rng = xorshift32(rng);
        tmp_idx = rng[7:0];
        rand_item(tmp_item);
        fork
            run_transfer(2, 1'b1, tmp_idx, tmp_item);
            begin
                while (!wb_cyc_w) @(negedge clk);
                repeat (6) @(negedge clk);
                stage_r = ST_TRANSLATE;
            end
        join
        run_transfer(3, 1'b0, tmp_idx, '0);

        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
design/huff_mem_pkg.sv
design/stage_select.sv
design/region_port.sv
design/wb_beat_master.sv
design/wb_sram.sv
design/huff_mem_top.sv
tb/huff_mem_asserts.sv
tb/huff_mem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module huff_mem_tb -f tb.f \
    -o sim_huff_mem > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_huff_mem > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
